// File: filelist.f
+incdir+include
rtl/enoc_pkg.sv
rtl/axil_if.sv
rtl/enoc_unpack.sv
rtl/enoc_pack.sv
rtl/enoc_axil_ctrl.sv
rtl/enoc_axil_mem.sv
rtl/enoc_bridge_top.sv
dv/enoc_tb_clk.sv
dv/enoc_bridge_chk.sv
dv/enoc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the bridge testbench with verilator
# exit status is nonzero when the testbench stops on a failure
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f filelist.f --top-module enoc_tb -o enoc_tb_sim

./obj_dir/enoc_tb_sim

// File: dv/enoc_tb.sv
// Bridge directed testbench
`timescale 1ns/1ps
`default_nettype none

`include "enoc_settings.svh"

module enoc_tb;
   import enoc_pkg::*;

   // fill, word rw, sub-word, atomics, cas, errors, back-pressure
   localparam int NUM_PKTS = `ENOC_MEM_WORDS + 32 + 16 + 15 + 5 + 6 + 24;
   localparam int CYCLE_NS = 100;

   logic        clk, rst;
   logic        packet_in_valid, packet_in_ready;
   packet_t     packet_in;
   logic        packet_out_valid, packet_out_ready;
   packet_t     packet_out;
   data_t       ref_mem [`ENOC_MEM_WORDS]; // expected memory words
   addr_t       exp_addr[$];               // outstanding responses, in order
   data_t       exp_data[$];
   logic [7:0]  exp_user[$];
   logic        exp_err[$];
   logic [31:0] rng = 32'h2c0d6ee6;

   enoc_tb_clk u_enoc_tb_clk (.clk (clk), .rst (rst));

   enoc_bridge_top u_enoc_bridge_top (
      .clk (clk), .rst (rst),
      .packet_in_valid (packet_in_valid), .packet_in_ready (packet_in_ready),
      .packet_in (packet_in), .packet_out_valid (packet_out_valid),
      .packet_out_ready (packet_out_ready), .packet_out (packet_out)
   );

   bind enoc_bridge_top enoc_bridge_chk u_enoc_bridge_chk (
      .clk (clk), .rst (rst),
      .packet_in_valid (packet_in_valid), .packet_in_ready (packet_in_ready),
      .packet_in (packet_in), .packet_out_valid (packet_out_valid),
      .packet_out_ready (packet_out_ready), .packet_out (packet_out),
      .rsp_valid (rsp_valid),
      .awvalid (u_axil.awvalid), .awready (u_axil.awready), .awaddr (u_axil.awaddr),
      .wvalid (u_axil.wvalid), .wready (u_axil.wready), .wdata (u_axil.wdata),
      .arvalid (u_axil.arvalid), .arready (u_axil.arready), .araddr (u_axil.araddr),
      .rvalid (u_axil.rvalid), .rready (u_axil.rready), .rdata (u_axil.rdata)
   );

   //########################################
   // helpers
   //########################################

   function automatic logic [31:0] xorshift();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic addr_t rand_word_addr(); // aligned, in range
      return {22'd0, 8'(xorshift()), 2'b00};
   endfunction

   function automatic data_t fill_word(input addr_t a);
      return (a * 32'h9e37_79b1) ^ 32'h5a5a_0f0f; // odd multiplier, all bits count
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
         $display("*** FAILED ***");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic step(); // next edge, then drive delay
      @(posedge clk);
      #10;
   endtask

   task automatic send(input packet_t p);
      packet_in       = p;
      packet_in_valid = 1'b1;
      while (!packet_in_ready) step();
      step();                    // taken on this edge
      packet_in_valid = 1'b0;
   endtask

   // model the request, queue its reply, then send it
   task automatic issue(input logic [3:0] op, input logic [2:0] size, input addr_t addr,
                        input data_t lo, input data_t hi);
      logic [7:0] user;
      logic       ok;
      int         idx;
      logic [3:0] strb;
      data_t      dat, mask, old, upd;
      user = 8'(xorshift());
      ok   = addr < 32'(4 * `ENOC_MEM_WORDS);
      idx  = int'(addr[31:2]);
      old  = ok ? ref_mem[idx] : '0;          // out of range reads zero
      upd  = old;
      case (op)
         OP_WRITE: begin
            if (size == SIZE_BYTE) begin
               strb = 4'b0001 << addr[1:0];
               dat  = {4{lo[7:0]}};
            end else if (size == SIZE_HALF) begin
               strb = addr[1] ? 4'b1100 : 4'b0011; // aligned half
               dat  = {2{lo[15:0]}};
            end else begin
               strb = 4'b1111;
               dat  = lo;
            end
            mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
            upd  = (old & ~mask) | (dat & mask);
         end
         OP_ADD:  upd = old + lo; // wraps
         OP_AND:  upd = old & lo;
         OP_OR:   upd = old | lo;
         OP_XOR:  upd = old ^ lo;
         OP_CAS:  if (old == lo) upd = hi;
         default: upd = old;
      endcase
      if (ok && op <= OP_CAS) ref_mem[idx] = upd;
      if (op != OP_WRITE && op <= OP_CAS) begin
         exp_addr.push_back(lo);  // src field is the reply address
         exp_data.push_back(old);
         exp_user.push_back(user);
         exp_err.push_back(!ok);
      end
      send({hi, lo, addr, user, 1'b0, size, op});
   endtask

   // take one reply, optionally with random ready stalls
   task automatic collect(input bit stall);
      logic [31:0] r;
      logic        done;
      logic [15:0] cmd;
      done = 1'b0;
      while (!done) begin
         r = xorshift();
         packet_out_ready = !stall || r[0];
         if (packet_out_valid && packet_out_ready) done = 1'b1;
         else step();
      end
      if (exp_data.size() == 0) begin
         $display("response packet arrived with no request outstanding");
         $display("*** FAILED ***");
         $fatal(1, "unexpected response");
      end
      cmd = {exp_user.pop_front(), exp_err.pop_front(), SIZE_WORD, OP_WRITE};
      check("packet_out.cmd", 32'(cmd), 32'(packet_out[15:0]));
      check("packet_out.dstaddr", exp_addr.pop_front(), packet_out[47:16]);
      check("packet_out.data_lo", exp_data.pop_front(), packet_out[79:48]);
      check("packet_out.data_hi", 32'h0, packet_out[111:80]);
      step();
      packet_out_ready = 1'b0; // a stray reply waits for the next collect
   endtask

   //########################################
   // directed tests
   //########################################

   task automatic test_word_rw();
      addr_t a;
      repeat (16) begin
         a = rand_word_addr();
         issue(OP_WRITE, SIZE_WORD, a, xorshift(), '0);
         issue(OP_READ, SIZE_WORD, a, xorshift(), '0);
         collect(1'b0);
      end
   endtask

   task automatic test_sub_word();
      addr_t a;
      for (int lane = 0; lane < 4; lane++) begin
         a = 32'h0000_0200 | 32'(lane);
         issue(OP_WRITE, SIZE_BYTE, a, xorshift(), '0);
         issue(OP_READ, SIZE_WORD, a, xorshift(), '0);
         collect(1'b0);
         issue(OP_WRITE, SIZE_HALF, a + 32'h10, xorshift(), '0);
         issue(OP_READ, SIZE_WORD, a + 32'h10, xorshift(), '0);
         collect(1'b0);
      end
   endtask

   task automatic test_atomics();
      addr_t a;
      a = 32'h0000_0300;
      issue(OP_WRITE, SIZE_WORD, a, 32'hffff_fff0, '0);
      issue(OP_ADD, SIZE_WORD, a, 32'h0000_0025, '0); // carries out of bit 31
      collect(1'b0);
      issue(OP_READ, SIZE_WORD, a, xorshift(), '0);
      collect(1'b0);
      for (int op = 2; op <= 5; op++) begin          // add, and, or, xor
         a = a + 4;
         issue(OP_WRITE, SIZE_WORD, a, xorshift(), '0);
         issue(4'(op), SIZE_WORD, a, xorshift(), '0);
         collect(1'b0);
         issue(OP_READ, SIZE_WORD, a, xorshift(), '0);
         collect(1'b0);
      end
   endtask

   task automatic test_cas();
      addr_t a;
      a = 32'h0000_0380;
      issue(OP_WRITE, SIZE_WORD, a, 32'h1234_5678, '0);
      issue(OP_CAS, SIZE_WORD, a, 32'h1234_5678, 32'hcafe_f00d); // match
      collect(1'b0);
      issue(OP_READ, SIZE_WORD, a, xorshift(), '0);
      collect(1'b0);
      issue(OP_CAS, SIZE_WORD, a, 32'h1234_5678, 32'h0bad_0bad); // stale compare
      collect(1'b0);
      issue(OP_READ, SIZE_WORD, a, xorshift(), '0);
      collect(1'b0);
   endtask

   task automatic test_errors();
      issue(OP_WRITE, SIZE_WORD, 32'h0000_0000, 32'h0f1e_2d3c, '0);
      issue(OP_WRITE, SIZE_WORD, 32'h0000_0400, 32'hdead_beef, '0); // would alias word 0
      issue(OP_READ, SIZE_WORD, 32'h0000_0000, xorshift(), '0);
      collect(1'b0);
      issue(OP_READ, SIZE_WORD, 32'h8000_0404, xorshift(), '0);  // zero plus err flag
      collect(1'b0);
      issue(4'hb, SIZE_WORD, 32'h0000_0010, xorshift(), '0);      // unsupported, dropped
      repeat (20) begin
         step();
         check("packet_out_valid", 32'h0, 32'(packet_out_valid));
      end
      issue(OP_READ, SIZE_WORD, 32'h0000_0010, xorshift(), '0);
      collect(1'b0);
   endtask

   task automatic test_backpressure();
      fork
         repeat (24) issue(OP_READ, SIZE_WORD, rand_word_addr(), xorshift(), '0);
         repeat (24) collect(1'b1);
      join
   endtask

   //########################################
   // main sequence and watchdog
   //########################################

   initial begin
      packet_in_valid  = 1'b0;
      packet_in        = '0;
      packet_out_ready = 1'b0;
      @(negedge rst);
      for (int i = 0; i < `ENOC_MEM_WORDS; i++) begin // known contents everywhere
         issue(OP_WRITE, SIZE_WORD, 32'(4 * i), fill_word(32'(4 * i)), '0);
      end
      test_word_rw();
      test_sub_word();
      test_atomics();
      test_cas();
      test_errors();
      test_backpressure();
      $display("*** PASSED ***");
      $finish;
   end

   initial begin
      #(NUM_PKTS * 40 * CYCLE_NS + 100 * CYCLE_NS);
      $display("watchdog expired before the tests finished");
      $display("*** FAILED ***");
      $fatal(1, "timeout");
   end

endmodule

`default_nettype wire

// File: dv/enoc_bridge_chk.sv
// Bridge handshake assertions
`timescale 1ns/1ps
`default_nettype none

module enoc_bridge_chk (
   input logic              clk,
   input logic              rst,
   input logic              packet_in_valid,
   input logic              packet_in_ready,
   input enoc_pkg::packet_t packet_in,
   input logic              packet_out_valid,
   input logic              packet_out_ready,
   input enoc_pkg::packet_t packet_out,
   input logic              rsp_valid,
   input logic              awvalid, awready, wvalid, wready,
   input logic              arvalid, arready, rvalid, rready,
   input enoc_pkg::addr_t   awaddr, araddr,
   input enoc_pkg::data_t   wdata, rdata
);

   //########################################
   // valid holds with stable payload
   //########################################

   a_pkt_in_hold: assert property (@(posedge clk) disable iff (rst)
      packet_in_valid && !packet_in_ready |=> packet_in_valid && $stable(packet_in))
      else $error("request dropped or changed before packet_in_ready");

   a_pkt_out_hold: assert property (@(posedge clk) disable iff (rst)
      packet_out_valid && !packet_out_ready |=> packet_out_valid && $stable(packet_out))
      else $error("response dropped or changed under back-pressure");

   a_aw_hold: assert property (@(posedge clk) disable iff (rst)
      awvalid && !awready |=> awvalid && $stable(awaddr))
      else $error("aw channel changed before awready");

   a_w_hold: assert property (@(posedge clk) disable iff (rst)
      wvalid && !wready |=> wvalid && $stable(wdata))
      else $error("w channel changed before wready");

   a_ar_hold: assert property (@(posedge clk) disable iff (rst)
      arvalid && !arready |=> arvalid && $stable(araddr))
      else $error("ar channel changed before arready");

   a_r_hold: assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rdata))
      else $error("r channel changed before rready");

   // reset values
   a_reset_out: assert property (@(posedge clk) rst |=> !packet_out_valid)
      else $error("packet_out_valid high right after reset");

   // full output register keeps the controller in respond, so no new request
   a_in_blocked: assert property (@(posedge clk) disable iff (rst)
      rsp_valid && packet_out_valid && !packet_out_ready |=> !packet_in_ready)
      else $error("packet_in_ready high while a response waits");

endmodule

`default_nettype wire

// File: dv/enoc_tb_clk.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module enoc_tb_clk (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk; // 100 ns period
   end

   // sync reset, held 8 cycles, released just after an edge
   initial begin
      rst = 1'b1;
      repeat (8) @(posedge clk);
      #10 rst = 1'b0;
   end

endmodule

`default_nettype wire

// File: rtl/enoc_bridge_top.sv
// Mesh packet to memory bridge
`timescale 1ns/1ps
`default_nettype none

module enoc_bridge_top (
   input  logic              clk,
   input  logic              rst,
   input  logic              packet_in_valid,
   output logic              packet_in_ready,
   input  enoc_pkg::packet_t packet_in,
   output logic              packet_out_valid,
   input  logic              packet_out_ready,
   output enoc_pkg::packet_t packet_out
);
   import enoc_pkg::*;

   opcode_e    opcode;
   logic       is_write, is_read, is_atomic, is_cas, is_supported;
   logic [7:0] user;
   addr_t      dstaddr, srcaddr;
   data_t      data_lo, data_hi;
   strb_t      wstrb;
   logic       rsp_valid, rsp_ready, rsp_err;
   addr_t      rsp_addr;
   data_t      rsp_data;
   logic [7:0] rsp_user;

   axil_if u_axil ();

   //########################################
   // request path, ctrl, local memory
   //########################################

   enoc_unpack u_enoc_unpack (
      .packet_in (packet_in), .opcode (opcode), .is_write (is_write),
      .is_read (is_read), .is_atomic (is_atomic), .is_cas (is_cas),
      .is_supported (is_supported), .user (user), .dstaddr (dstaddr),
      .srcaddr (srcaddr), .data_lo (data_lo), .data_hi (data_hi), .wstrb (wstrb)
   );

   enoc_axil_ctrl u_enoc_axil_ctrl (
      .clk (clk), .rst (rst),
      .packet_in_valid (packet_in_valid), .packet_in_ready (packet_in_ready),
      .opcode (opcode), .is_write (is_write), .is_read (is_read),
      .is_atomic (is_atomic), .is_cas (is_cas), .is_supported (is_supported),
      .user (user), .dstaddr (dstaddr), .srcaddr (srcaddr),
      .data_lo (data_lo), .data_hi (data_hi), .wstrb (wstrb),
      .axil (u_axil.master),
      .rsp_valid (rsp_valid), .rsp_ready (rsp_ready), .rsp_addr (rsp_addr),
      .rsp_data (rsp_data), .rsp_user (rsp_user), .rsp_err (rsp_err)
   );

   enoc_axil_mem u_enoc_axil_mem (.clk (clk), .rst (rst), .axil (u_axil.slave));

   // response path
   enoc_pack u_enoc_pack (
      .clk (clk), .rst (rst),
      .rsp_valid (rsp_valid), .rsp_ready (rsp_ready), .rsp_addr (rsp_addr),
      .rsp_data (rsp_data), .rsp_user (rsp_user), .rsp_err (rsp_err),
      .packet_out_valid (packet_out_valid), .packet_out_ready (packet_out_ready),
      .packet_out (packet_out)
   );

endmodule

`default_nettype wire

// File: rtl/enoc_axil_mem.sv
// AXI4-Lite word memory
`timescale 1ns/1ps
`default_nettype none

`include "enoc_settings.svh"

module enoc_axil_mem (
   input  logic   clk,
   input  logic   rst,
   axil_if.slave  axil
);
   import enoc_pkg::*;

   localparam int IDX_W = $clog2(`ENOC_MEM_WORDS);

   data_t      mem [`ENOC_MEM_WORDS];
   logic       bvalid_r, rvalid_r;
   logic [1:0] bresp_r, rresp_r;
   data_t      rdata_r;
   logic       aw_fire, ar_fire;

   // anything above the top word gets slverr
   function automatic logic in_range(input addr_t a);
      return (a >> (IDX_W + 2)) == '0;
   endfunction

   //########################################
   // handshakes
   //########################################

   assign axil.awready = axil.awvalid && axil.wvalid && !bvalid_r; // aw and w together
   assign axil.wready  = axil.awvalid && axil.wvalid && !bvalid_r;
   assign axil.arready = !rvalid_r;  // idle read channel
   assign aw_fire = axil.awvalid && axil.awready;
   assign ar_fire = axil.arvalid && axil.arready;

   assign axil.bvalid = bvalid_r;
   assign axil.bresp  = bresp_r;
   assign axil.rvalid = rvalid_r;
   assign axil.rresp  = rresp_r;
   assign axil.rdata  = rdata_r;

   always_ff @(posedge clk) begin
      if (rst) begin
         bvalid_r <= 1'b0;
         rvalid_r <= 1'b0;
      end else begin
         if (aw_fire)          bvalid_r <= 1'b1;  // one cycle after the write
         else if (axil.bready) bvalid_r <= 1'b0;
         if (ar_fire)          rvalid_r <= 1'b1;
         else if (axil.rready) rvalid_r <= 1'b0;
      end
   end

   //########################################
   // storage
   //########################################

   always_ff @(posedge clk) begin
      if (aw_fire) begin
         bresp_r <= in_range(axil.awaddr) ? RESP_OKAY : RESP_SLVERR;
         if (in_range(axil.awaddr)) begin // out of range is dropped
            for (int i = 0; i < $bits(strb_t); i++) begin
               if (axil.wstrb[i]) mem[axil.awaddr[IDX_W+1:2]][8*i +: 8] <= axil.wdata[8*i +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ar_fire) begin
         if (in_range(axil.araddr)) begin
            rdata_r <= mem[axil.araddr[IDX_W+1:2]];
            rresp_r <= RESP_OKAY;
         end else begin
            rdata_r <= '0;   // zero on error
            rresp_r <= RESP_SLVERR;
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/enoc_axil_ctrl.sv
// Packet to AXI4-Lite controller
`timescale 1ns/1ps
`default_nettype none

module enoc_axil_ctrl (
   input  logic              clk,
   input  logic              rst,
   input  logic              packet_in_valid,
   output logic              packet_in_ready,
   input  enoc_pkg::opcode_e opcode,
   input  logic              is_write,
   input  logic              is_read,
   input  logic              is_atomic,
   input  logic              is_cas,
   input  logic              is_supported,
   input  logic [7:0]        user,
   input  enoc_pkg::addr_t   dstaddr,
   input  enoc_pkg::addr_t   srcaddr,
   input  enoc_pkg::data_t   data_lo,
   input  enoc_pkg::data_t   data_hi,
   input  enoc_pkg::strb_t   wstrb,
   axil_if.master            axil,
   output logic              rsp_valid,
   input  logic              rsp_ready,
   output enoc_pkg::addr_t   rsp_addr,
   output enoc_pkg::data_t   rsp_data,
   output logic [7:0]        rsp_user,
   output logic              rsp_err
);
   import enoc_pkg::*;

   ctrl_state_e state;
   opcode_e     op_r;
   logic        atomic_r, cas_r;
   addr_t       addr_r, src_r;
   data_t       wdata_r, swap_r, old_r, new_word;
   strb_t       strb_r;
   logic [7:0]  user_r;
   logic        err_r;
   logic        awvalid_r, wvalid_r, bready_r, arvalid_r, rready_r;
   logic        in_fire, b_fire, r_fire, do_modify;

   assign packet_in_ready = (state == ST_IDLE); // one request in flight
   assign in_fire = packet_in_valid && packet_in_ready;
   assign b_fire  = axil.bvalid && bready_r;
   assign r_fire  = axil.rvalid && rready_r;

   // atomics always write back, cas only on a match
   assign do_modify = atomic_r || (cas_r && (axil.rdata == wdata_r));

   //########################################
   // axi master side
   //########################################

   assign axil.awaddr  = {addr_r[$bits(addr_t)-1:2], 2'b00}; // lanes pick the bytes
   assign axil.araddr  = {addr_r[$bits(addr_t)-1:2], 2'b00};
   assign axil.awvalid = awvalid_r;
   assign axil.wvalid  = wvalid_r;
   assign axil.wdata   = wdata_r;
   assign axil.wstrb   = strb_r;
   assign axil.bready  = bready_r;
   assign axil.arvalid = arvalid_r;
   assign axil.rready  = rready_r;

   // new word for the rmw write
   always_comb begin
      case (op_r)
         OP_ADD:  new_word = axil.rdata + wdata_r; // wraps at 32 bits
         OP_AND:  new_word = axil.rdata & wdata_r;
         OP_OR:   new_word = axil.rdata | wdata_r;
         OP_XOR:  new_word = axil.rdata ^ wdata_r;
         OP_CAS:  new_word = swap_r;
         default: new_word = axil.rdata;
      endcase
   end

   //########################################
   // fsm
   //########################################

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= ST_IDLE;
         awvalid_r <= 1'b0;
         wvalid_r  <= 1'b0;
         bready_r  <= 1'b0;
         arvalid_r <= 1'b0;
         rready_r  <= 1'b0;
      end else begin
         if (awvalid_r && axil.awready) awvalid_r <= 1'b0;
         if (wvalid_r && axil.wready)   wvalid_r  <= 1'b0;
         if (arvalid_r && axil.arready) arvalid_r <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (in_fire && is_supported) begin
                  if (is_write) begin        // posted
                     state     <= ST_WRITE;
                     awvalid_r <= 1'b1;
                     wvalid_r  <= 1'b1;
                     bready_r  <= 1'b1;
                  end else if (is_read || is_atomic || is_cas) begin
                     state     <= ST_READ;
                     arvalid_r <= 1'b1;
                     rready_r  <= 1'b1;
                  end
               end
            end
            ST_WRITE: begin
               if (b_fire) begin
                  bready_r <= 1'b0;
                  state    <= ST_IDLE;      // no reply for writes
               end
            end
            ST_READ: begin
               if (r_fire) begin
                  rready_r <= 1'b0;
                  if (do_modify) begin
                     state     <= ST_MODIFY_WRITE;
                     awvalid_r <= 1'b1;
                     wvalid_r  <= 1'b1;
                     bready_r  <= 1'b1;
                  end else begin
                     state <= ST_RESPOND;   // read, or failed cas
                  end
               end
            end
            ST_MODIFY_WRITE: begin
               if (b_fire) begin
                  bready_r <= 1'b0;
                  state    <= ST_RESPOND;
               end
            end
            ST_RESPOND: begin
               if (rsp_ready) state <= ST_IDLE; // stalls under back-pressure
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   //########################################
   // request fields and result
   //########################################

   always_ff @(posedge clk) begin
      if (in_fire) begin
         op_r     <= opcode;
         atomic_r <= is_atomic;
         cas_r    <= is_cas;
         addr_r   <= dstaddr;
         src_r    <= srcaddr;   // reply goes here
         user_r   <= user;
         wdata_r  <= data_lo;   // write data, operand or compare value
         swap_r   <= data_hi;
         strb_r   <= wstrb;
         err_r    <= 1'b0;
      end
      if (b_fire && (axil.bresp != RESP_OKAY)) err_r <= 1'b1;
      if (r_fire) begin
         old_r   <= axil.rdata;
         wdata_r <= new_word;
         if (axil.rresp != RESP_OKAY) err_r <= 1'b1;
      end
   end

   assign rsp_valid = (state == ST_RESPOND);
   assign rsp_addr  = src_r;
   assign rsp_data  = old_r;   // old memory word
   assign rsp_user  = user_r;
   assign rsp_err   = err_r;

endmodule

`default_nettype wire

// File: rtl/enoc_pack.sv
// Response packet pack and output register
`timescale 1ns/1ps
`default_nettype none

module enoc_pack (
   input  logic              clk,
   input  logic              rst,
   input  logic              rsp_valid,
   output logic              rsp_ready,
   input  enoc_pkg::addr_t   rsp_addr,
   input  enoc_pkg::data_t   rsp_data,
   input  logic [7:0]        rsp_user,
   input  logic              rsp_err,
   output logic              packet_out_valid,
   input  logic              packet_out_ready,
   output enoc_pkg::packet_t packet_out
);
   import enoc_pkg::*;

   logic [15:0] cmd;
   packet_t     pkt_next;

   // reply is always a word write back to the requester
   assign cmd      = {rsp_user, rsp_err, SIZE_WORD, OP_WRITE};
   assign pkt_next = {{$bits(data_t){1'b0}}, rsp_data, rsp_addr, cmd}; // hi word zero

   // take a new one when empty or draining this cycle
   assign rsp_ready = !packet_out_valid || packet_out_ready;

   //########################################
   // output register
   //########################################

   always_ff @(posedge clk) begin
      if (rst) begin
         packet_out_valid <= 1'b0;
      end else if (rsp_valid && rsp_ready) begin
         packet_out_valid <= 1'b1;
      end else if (packet_out_ready) begin
         packet_out_valid <= 1'b0;  // drained
      end
   end

   always_ff @(posedge clk) begin
      if (rsp_valid && rsp_ready) begin
         packet_out <= pkt_next; // held until taken
      end
   end

endmodule

`default_nettype wire

// File: rtl/enoc_unpack.sv
// Request packet unpack and decode
`timescale 1ns/1ps
`default_nettype none

module enoc_unpack (
   input  enoc_pkg::packet_t packet_in,
   output enoc_pkg::opcode_e opcode,
   output logic              is_write,
   output logic              is_read,
   output logic              is_atomic,
   output logic              is_cas,
   output logic              is_supported,
   output logic [7:0]        user,
   output enoc_pkg::addr_t   dstaddr,
   output enoc_pkg::addr_t   srcaddr,
   output enoc_pkg::data_t   data_lo,
   output enoc_pkg::data_t   data_hi,
   output enoc_pkg::strb_t   wstrb
);
   import enoc_pkg::*;

   size_e size;

   //########################################
   // field split, 112-bit layout
   //########################################

   assign opcode  = opcode_e'(packet_in[3:0]);
   assign size    = size_e'(packet_in[6:4]);
   // bit 7 is the error flag, only meaningful in responses
   assign user    = packet_in[15:8];
   assign dstaddr = packet_in[16 +: $bits(addr_t)];
   assign srcaddr = packet_in[48 +: $bits(addr_t)]; // doubles as data lo
   assign data_hi = packet_in[80 +: $bits(data_t)];

   //########################################
   // command decode
   //########################################

   assign is_write     = (packet_in[3:0] == OP_WRITE);
   assign is_read      = (packet_in[3:0] == OP_READ);
   assign is_cas       = (packet_in[3:0] == OP_CAS);
   assign is_atomic    = (packet_in[3:0] == OP_ADD) || (packet_in[3:0] == OP_AND) ||
                         (packet_in[3:0] == OP_OR)  || (packet_in[3:0] == OP_XOR);
   assign is_supported = (packet_in[3:0] <= OP_CAS); // 7..15 get dropped

   // strobe and lane replication, only plain writes honour size
   always_comb begin
      wstrb   = '1;                               // rmw ops use the whole word
      data_lo = packet_in[48 +: $bits(data_t)];
      if (is_write) begin
         case (size)
            SIZE_BYTE: begin
               wstrb   = strb_t'(4'b0001 << dstaddr[1:0]);
               data_lo = {4{packet_in[55:48]}};   // byte on every lane
            end
            SIZE_HALF: begin
               wstrb   = strb_t'(4'b0011 << {dstaddr[1], 1'b0}); // aligned half
               data_lo = {2{packet_in[63:48]}};
            end
            default: begin
               wstrb   = '1; // word, also odd sizes
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rtl/axil_if.sv
// AXI4-Lite bundle
`timescale 1ns/1ps
`default_nettype none

interface axil_if;
   import enoc_pkg::*;

   // write address / data
   addr_t      awaddr;
   logic       awvalid;
   logic       awready;
   data_t      wdata;
   strb_t      wstrb;
   logic       wvalid;
   logic       wready;
   // write response
   logic [1:0] bresp;
   logic       bvalid;
   logic       bready;
   // read address / data
   addr_t      araddr;
   logic       arvalid;
   logic       arready;
   data_t      rdata;
   logic [1:0] rresp;
   logic       rvalid;
   logic       rready;

   modport master (
      output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
      input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
   );

   modport slave (
      input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
      output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
   );

endinterface

`default_nettype wire

// File: rtl/enoc_pkg.sv
// Mesh bridge types
`default_nettype none

`include "enoc_settings.svh"

package enoc_pkg;

   //########################################
   // vectors with a meaning
   //########################################

   typedef logic [`ENOC_PW-1:0]   packet_t; // full mesh packet
   typedef logic [`ENOC_AW-1:0]   addr_t;   // byte address
   typedef logic [`ENOC_DW-1:0]   data_t;   // one memory word
   typedef logic [`ENOC_DW/8-1:0] strb_t;   // byte lanes

   // command bits 3..0
   typedef enum logic [3:0] {
      OP_WRITE = 4'd0,
      OP_READ  = 4'd1,
      OP_ADD   = 4'd2,
      OP_AND   = 4'd3,
      OP_OR    = 4'd4,
      OP_XOR   = 4'd5,
      OP_CAS   = 4'd6
   } opcode_e;

   // command bits 6..4
   typedef enum logic [2:0] {
      SIZE_BYTE = 3'd0,
      SIZE_HALF = 3'd1,
      SIZE_WORD = 3'd2
   } size_e;

   // controller fsm
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WRITE,
      ST_READ,
      ST_MODIFY_WRITE,
      ST_RESPOND
   } ctrl_state_e;

   // axi response codes, only two are ever produced
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: include/enoc_settings.svh
// Mesh bridge width settings

`ifndef ENOC_SETTINGS_SVH
`define ENOC_SETTINGS_SVH

//########################################
// packet format, 32-bit address family
//########################################

// address width, also src/dst field width
`define ENOC_AW 32

// cmd(16) + dst(32) + src/data lo(32) + data hi(32)
`define ENOC_PW 112

//########################################
// local memory side
//########################################

`define ENOC_DW 32 // axi4-lite data width

// depth in words, bytes 0..1023 valid
`define ENOC_MEM_WORDS 256

`endif
